// File: design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// first fetch address after reset, start of ram
`define RV_RESET_PC     64'h0000_0000_8000_0000

// clint window, mtime at base and mtimecmp at base + 8
`define RV_CLINT_BASE   64'h0000_0000_0200_0000

// result slots written by the test program
`define RV_MAILBOX_BASE 64'h0000_0000_8000_1000

// a store here marks the end of the program
`define RV_DONE_ADDR    64'h0000_0000_8000_1ff8

`endif

// File: design/rv_pkg.sv
package rv_pkg;

    // supported operations, anything else decodes as nop
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LUI,
        OP_AUIPC,
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_LD,
        OP_SD,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_CSRRW,
        OP_MRET
    } op_e;

    // one decoded instruction
    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] imm;
        logic [11:0] csr;
    } decoded_t;

    // machine csr indices
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // msb set for interrupts
    localparam logic [63:0] CAUSE_M_EXT   = 64'h8000_0000_0000_000b;
    localparam logic [63:0] CAUSE_M_TIMER = 64'h8000_0000_0000_0007;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY
    } fsm_state_e;

endpackage

// File: design/rv_bus_if.sv
// one data access with a valid/ready handshake
interface rv_bus_if;
    logic        valid;
    logic        write;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic        ready;
    logic [63:0] rdata;

    // requester side
    modport master (
        output valid,
        output write,
        output addr,
        output wdata,
        input  ready,
        input  rdata
    );

    // responder side
    modport slave (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        output ready,
        output rdata
    );
endinterface

// File: design/rv_decoder.sv
module rv_decoder (
    input  logic [31:0]      ir,
    output rv_pkg::decoded_t dec
);
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [63:0] imm_u;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_j;
    logic [63:0] imm_b;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    // sign extended immediates, one per format
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    // jal and beq offsets are in half words, low bit is always 0
    assign imm_j = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    assign imm_b = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};

    always_comb begin
        dec.op  = rv_pkg::OP_NOP;
        dec.rd  = ir[11:7];
        dec.rs1 = ir[19:15];
        dec.rs2 = ir[24:20];
        dec.imm = imm_i;
        dec.csr = ir[31:20];
        case (opcode)
            7'b0110111: begin
                dec.op  = rv_pkg::OP_LUI;
                dec.imm = imm_u;
            end
            7'b0010111: begin
                dec.op  = rv_pkg::OP_AUIPC;
                dec.imm = imm_u;
            end
            7'b0010011: begin
                if (funct3 == 3'b000) dec.op = rv_pkg::OP_ADDI;
            end
            7'b0110011: begin
                // add, sub and slt only
                if (funct3 == 3'b000 && funct7 == 7'b0000000) dec.op = rv_pkg::OP_ADD;
                if (funct3 == 3'b000 && funct7 == 7'b0100000) dec.op = rv_pkg::OP_SUB;
                if (funct3 == 3'b010 && funct7 == 7'b0000000) dec.op = rv_pkg::OP_SLT;
            end
            7'b0000011: begin
                if (funct3 == 3'b011) dec.op = rv_pkg::OP_LD;
            end
            7'b0100011: begin
                dec.imm = imm_s;
                if (funct3 == 3'b011) dec.op = rv_pkg::OP_SD;
            end
            7'b1101111: begin
                dec.op  = rv_pkg::OP_JAL;
                dec.imm = imm_j;
            end
            7'b1100111: begin
                if (funct3 == 3'b000) dec.op = rv_pkg::OP_JALR;
            end
            7'b1100011: begin
                dec.imm = imm_b;
                if (funct3 == 3'b000) dec.op = rv_pkg::OP_BEQ;
            end
            7'b1110011: begin
                if (funct3 == 3'b001) begin
                    dec.op = rv_pkg::OP_CSRRW;
                end else if (ir[31:7] == {12'h302, 13'd0}) begin
                    // mret is 0x30200073
                    dec.op = rv_pkg::OP_MRET;
                end
            end
            default: dec.op = rv_pkg::OP_NOP;
        endcase
    end
endmodule

// File: design/rv_regfile.sv
module rv_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [63:0] rs1_data,
    output logic [63:0] rs2_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [63:0] wr_data
);
    logic [63:0] regs [0:31];

    // asynchronous reads, x0 is cleared by reset and its entry is never written
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            regs[0] <= 64'd0;
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 must survive any write sequence
    a_x0_zero: assert property (@(posedge clk) disable iff (!reset)
        rs1_addr == 5'd0 |-> rs1_data == 64'd0);
endmodule

// File: design/rv_csr.sv
module rv_csr (
    input  logic        clk,
    input  logic        reset,
    input  logic        ext_irq,
    input  logic        timer_irq,
    output logic        irq_pending,
    input  logic [11:0] csr_addr,
    input  logic        csr_wen,
    input  logic [63:0] csr_wdata,
    output logic [63:0] csr_rdata,
    input  logic        trap_enter,
    input  logic [63:0] trap_pc,
    input  logic        mret,
    output logic [63:0] mtvec,
    output logic [63:0] mepc,
    output logic        ext_ack
);
    logic        mstatus_mie;
    logic        mstatus_mpie;
    logic        mie_meie;
    logic        mie_mtie;
    logic [63:0] mcause;

    // global enable gates both sources
    assign irq_pending = mstatus_mie & ((ext_irq & mie_meie) | (timer_irq & mie_mtie));
    // external wins over timer
    assign ext_ack = mstatus_mie & ext_irq & mie_meie;

    // old value, read before the csrrw write lands
    always_comb begin
        case (csr_addr)
            // mpp reads as machine mode
            rv_pkg::CSR_MSTATUS: csr_rdata = {51'd0, 2'b11, 3'd0, mstatus_mpie, 3'd0,
                                              mstatus_mie, 3'd0};
            rv_pkg::CSR_MIE:     csr_rdata = {52'd0, mie_meie, 3'd0, mie_mtie, 7'd0};
            rv_pkg::CSR_MTVEC:   csr_rdata = mtvec;
            rv_pkg::CSR_MEPC:    csr_rdata = mepc;
            rv_pkg::CSR_MCAUSE:  csr_rdata = mcause;
            default:             csr_rdata = 64'd0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_mie  <= 1'b1;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b1;
            mie_mtie     <= 1'b1;
            mtvec        <= 64'd0;
            mepc         <= 64'd0;
            mcause       <= 64'd0;
        end else if (trap_enter) begin
            mepc         <= trap_pc;
            mcause       <= ext_ack ? rv_pkg::CAUSE_M_EXT : rv_pkg::CAUSE_M_TIMER;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (csr_wen) begin
            case (csr_addr)
                rv_pkg::CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata[3];
                    mstatus_mpie <= csr_wdata[7];
                end
                rv_pkg::CSR_MIE: begin
                    mie_meie <= csr_wdata[11];
                    mie_mtie <= csr_wdata[7];
                end
                // direct mode only
                rv_pkg::CSR_MTVEC:  mtvec  <= {csr_wdata[63:1], 1'b0};
                rv_pkg::CSR_MEPC:   mepc   <= csr_wdata;
                rv_pkg::CSR_MCAUSE: mcause <= csr_wdata;
                default: ;
            endcase
        end
    end

    // trap entry happens in fetch, mret in execute
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (!reset)
        !(trap_enter && mret));
endmodule

// File: design/rv_clint.sv
`include "rv_params.svh"

module rv_clint (
    input  logic     clk,
    input  logic     reset,
    rv_bus_if.slave  core,
    rv_bus_if.master ext,
    output logic     timer_irq
);
    localparam logic [63:0] CLINT_BASE = `RV_CLINT_BASE;

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        hit;

    // 16 byte window, bit 3 picks mtimecmp
    assign hit = core.addr[63:4] == CLINT_BASE[63:4];

    // clint answers in the same cycle
    assign core.ready = hit ? 1'b1 : ext.ready;
    assign core.rdata = !hit ? ext.rdata : (core.addr[3] ? mtimecmp : mtime);

    // everything else goes out unchanged
    assign ext.valid = core.valid & ~hit;
    assign ext.write = core.write;
    assign ext.addr  = core.addr;
    assign ext.wdata = core.wdata;

    // level, held until software moves mtimecmp
    assign timer_irq = mtime >= mtimecmp;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mtime    <= 64'd0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtime + 64'd1;
            if (core.valid && core.write && hit) begin
                if (core.addr[3]) mtimecmp <= core.wdata;
                else mtime <= core.wdata;
            end
        end
    end

    // no access inside the 16 byte clint window may leak onto the memory bus
    a_no_clint_fwd: assert property (@(posedge clk) disable iff (!reset)
        ext.valid |-> ext.addr < CLINT_BASE || ext.addr >= CLINT_BASE + 64'd16);
endmodule

// File: design/rv_exec_fsm.sv
`include "rv_params.svh"

module rv_exec_fsm (
    input  logic             clk,
    input  logic             reset,
    output logic [63:0]      imem_addr,
    input  logic [31:0]      imem_data,
    output logic [31:0]      ir,
    input  rv_pkg::decoded_t dec,
    output logic [4:0]       rs1_addr,
    output logic [4:0]       rs2_addr,
    input  logic [63:0]      rs1_data,
    input  logic [63:0]      rs2_data,
    output logic             wr_en,
    output logic [4:0]       wr_addr,
    output logic [63:0]      wr_data,
    input  logic             irq_pending,
    input  logic             ext_ack,
    output logic [11:0]      csr_addr,
    output logic             csr_wen,
    output logic [63:0]      csr_wdata,
    input  logic [63:0]      csr_rdata,
    output logic             trap_enter,
    output logic [63:0]      trap_pc,
    output logic             mret,
    input  logic [63:0]      mtvec,
    input  logic [63:0]      mepc,
    rv_bus_if.master         bus,
    output logic             irq_ack
);
    rv_pkg::fsm_state_e state;
    logic [63:0]        pc;
    logic [63:0]        pc_next;
    logic [63:0]        sum_imm;
    logic               is_mem;
    logic               in_exec;
    logic               writes_rd;

    assign imem_addr = pc;
    assign rs1_addr  = dec.rs1;
    assign rs2_addr  = dec.rs2;
    assign in_exec   = state == rv_pkg::EXECUTE;

    // shared adder for addi, ld, sd and jalr
    assign sum_imm = rs1_data + dec.imm;
    assign is_mem  = dec.op == rv_pkg::OP_LD || dec.op == rv_pkg::OP_SD;

    // ir is held through memory, so these stay stable while waiting
    assign bus.valid = state == rv_pkg::MEMORY;
    assign bus.write = dec.op == rv_pkg::OP_SD;
    assign bus.addr  = sum_imm;
    assign bus.wdata = rs2_data;

    // interrupts are only taken between instructions
    assign trap_enter = state == rv_pkg::FETCH && irq_pending;
    assign trap_pc    = pc;
    assign mret       = in_exec && dec.op == rv_pkg::OP_MRET;
    assign csr_addr   = dec.csr;
    assign csr_wen    = in_exec && dec.op == rv_pkg::OP_CSRRW;
    assign csr_wdata  = rs1_data;

    always_comb begin
        case (dec.op)
            rv_pkg::OP_LUI, rv_pkg::OP_AUIPC, rv_pkg::OP_ADDI, rv_pkg::OP_ADD,
            rv_pkg::OP_SUB, rv_pkg::OP_SLT, rv_pkg::OP_JAL, rv_pkg::OP_JALR,
            rv_pkg::OP_CSRRW: writes_rd = 1'b1;
            default:          writes_rd = 1'b0;
        endcase
    end

    // ld writes back on the handshake cycle
    assign wr_en   = (in_exec && writes_rd) ||
                     (bus.valid && bus.ready && dec.op == rv_pkg::OP_LD);
    assign wr_addr = dec.rd;

    always_comb begin
        case (dec.op)
            rv_pkg::OP_LUI:   wr_data = dec.imm;
            rv_pkg::OP_AUIPC: wr_data = pc + dec.imm;
            rv_pkg::OP_ADDI:  wr_data = sum_imm;
            rv_pkg::OP_ADD:   wr_data = rs1_data + rs2_data;
            rv_pkg::OP_SUB:   wr_data = rs1_data - rs2_data;
            rv_pkg::OP_SLT:   wr_data = {63'd0, $signed(rs1_data) < $signed(rs2_data)};
            rv_pkg::OP_CSRRW: wr_data = csr_rdata;
            rv_pkg::OP_LD:    wr_data = bus.rdata;
            // link value for jal and jalr
            default:          wr_data = pc + 64'd4;
        endcase
    end

    // branch and jump resolution
    always_comb begin
        case (dec.op)
            rv_pkg::OP_JAL:  pc_next = pc + dec.imm;
            rv_pkg::OP_JALR: pc_next = {sum_imm[63:1], 1'b0};
            rv_pkg::OP_BEQ:  pc_next = (rs1_data == rs2_data) ? pc + dec.imm : pc + 64'd4;
            rv_pkg::OP_MRET: pc_next = mepc;
            default:         pc_next = pc + 64'd4;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= rv_pkg::FETCH;
            pc      <= `RV_RESET_PC;
            ir      <= 32'h0000_0013;
            irq_ack <= 1'b0;
        end else begin
            // one cycle pulse after an external trap entry
            irq_ack <= trap_enter & ext_ack;
            case (state)
                rv_pkg::FETCH: begin
                    if (irq_pending) begin
                        pc <= mtvec;
                    end else begin
                        ir    <= imem_data;
                        state <= rv_pkg::EXECUTE;
                    end
                end
                rv_pkg::EXECUTE: begin
                    pc    <= pc_next;
                    state <= is_mem ? rv_pkg::MEMORY : rv_pkg::FETCH;
                end
                rv_pkg::MEMORY: begin
                    if (bus.ready) state <= rv_pkg::FETCH;
                end
                default: state <= rv_pkg::FETCH;
            endcase
        end
    end

    // request stays put until it is accepted
    a_bus_stable: assert property (@(posedge clk) disable iff (!reset)
        bus.valid && !bus.ready |=> bus.valid && $stable(bus.write) &&
        $stable(bus.addr) && $stable(bus.wdata));
endmodule

// File: design/rv_core_top.sv
module rv_core_top (
    input  logic        clk,
    input  logic        reset,
    output logic [63:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic        mem_valid,
    output logic        mem_write,
    output logic [63:0] mem_addr,
    output logic [63:0] mem_wdata,
    input  logic        mem_ready,
    input  logic [63:0] mem_rdata,
    input  logic        irq_ext,
    output logic        irq_ack
);
    rv_pkg::decoded_t dec;
    logic [31:0]      ir;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [63:0]      rs1_data;
    logic [63:0]      rs2_data;
    logic             wr_en;
    logic [4:0]       wr_addr;
    logic [63:0]      wr_data;
    logic             irq_pending;
    logic             ext_ack;
    logic             timer_irq;
    logic [11:0]      csr_addr;
    logic             csr_wen;
    logic [63:0]      csr_wdata;
    logic [63:0]      csr_rdata;
    logic             trap_enter;
    logic [63:0]      trap_pc;
    logic             mret;
    logic [63:0]      mtvec;
    logic [63:0]      mepc;

    // core side and memory side of the clint
    rv_bus_if core_bus ();
    rv_bus_if mem_bus ();

    assign mem_valid     = mem_bus.valid;
    assign mem_write     = mem_bus.write;
    assign mem_addr      = mem_bus.addr;
    assign mem_wdata     = mem_bus.wdata;
    assign mem_bus.ready = mem_ready;
    assign mem_bus.rdata = mem_rdata;

    rv_exec_fsm u_fsm (
        .clk, .reset, .imem_addr, .imem_data, .ir, .dec,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .wr_en, .wr_addr, .wr_data,
        .irq_pending, .ext_ack, .csr_addr, .csr_wen, .csr_wdata, .csr_rdata,
        .trap_enter, .trap_pc, .mret, .mtvec, .mepc,
        .bus (core_bus.master), .irq_ack
    );

    rv_decoder u_dec (.ir, .dec);

    rv_regfile u_rf (
        .clk, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wr_en, .wr_addr, .wr_data
    );

    rv_csr u_csr (
        .clk, .reset, .ext_irq (irq_ext), .timer_irq, .irq_pending,
        .csr_addr, .csr_wen, .csr_wdata, .csr_rdata,
        .trap_enter, .trap_pc, .mret, .mtvec, .mepc, .ext_ack
    );

    rv_clint u_clint (
        .clk, .reset, .core (core_bus.slave), .ext (mem_bus.master), .timer_irq
    );
endmodule

// File: dv/tb_rv_mem.sv
`include "rv_params.svh"

module tb_rv_mem (
    input  logic        clk,
    input  logic        reset,
    input  logic [63:0] imem_addr,
    output logic [31:0] imem_data,
    input  logic        mem_valid,
    input  logic        mem_write,
    input  logic [63:0] mem_addr,
    input  logic [63:0] mem_wdata,
    output logic        mem_ready,
    output logic [63:0] mem_rdata,
    output logic        first_store,
    output logic        done,
    output int          error_count,
    output int          tests_passed,
    output int          tests_failed
);
    localparam logic [63:0] RESET_PC     = `RV_RESET_PC;
    localparam logic [63:0] MAILBOX      = `RV_MAILBOX_BASE;
    // scratch window for the sd/ld round trip, 16 doublewords
    localparam logic [63:0] SCRATCH_BASE = MAILBOX + 64'h400;
    localparam int          POISON_SLOT  = 15;
    localparam int          NUM_TESTS    = 5;

    logic [31:0] rom [0:63];
    logic [63:0] scratch [0:15];
    logic [63:0] fetch_offset;
    logic [31:0] stored = '0;
    logic [31:0] slot_bad = '0;
    logic [4:0]  reported = '0;
    logic        ready_q = 1'b0;
    int          last_main = -1;
    int          store_errors = 0;
    int          stable_errors = 0;
    integer      seed = 32'hed3d26b7;

    initial begin
        for (int i = 0; i < 64; i++) begin
            rom[i] = 32'h0000_0013;
        end
        // fill depends on the full byte address of each entry
        for (int i = 0; i < 16; i++) begin
            scratch[i] = (SCRATCH_BASE + 64'(i * 8)) ^ 64'h5a5a_5a5a_0000_0000;
        end
        $readmemh("dv/program.hex", rom);
        first_store  = 1'b0;
        done         = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
    end

    // asynchronous fetch, nop outside the loaded image
    assign fetch_offset = imem_addr - RESET_PC;
    assign imem_data    = (fetch_offset < 64'd256) ? rom[fetch_offset[7:2]] : 32'h0000_0013;

    assign mem_rdata   = scratch[mem_addr[6:3]];
    assign mem_ready   = ready_q;
    assign error_count = store_errors + stable_errors;

    // random back-pressure, changes on the falling edge
    always @(negedge clk) begin
        ready_q <= reset ? $random(seed) & 1 : 1'b0;
    end

    // expected mailbox contents, from the RV64 rules applied to each program step
    function automatic logic [63:0] expected_value(input int slot);
        case (slot)
            0:  expected_value = 64'h0000_0000_1234_5000;  // lui 0x12345
            1:  expected_value = RESET_PC + 64'h1000;      // auipc 1 at the reset pc
            2:  expected_value = -64'sd5;                  // addi x0 - 5
            3:  expected_value = 64'd2;                    // -5 + 7
            4:  expected_value = -64'sd12;                 // -5 - 7
            5:  expected_value = 64'd1;                    // -5 < 7 signed
            6:  expected_value = 64'd0;                    // 7 < -5 is false
            7:  expected_value = 64'hffff_ffff_abcd_e123;  // lui sign extends in RV64
            8:  expected_value = RESET_PC + 64'h68 + 64'd4;
            9:  expected_value = RESET_PC + 64'h78 + 64'd4;
            10: expected_value = 64'd7;                    // beq not taken marker
            11: expected_value = -64'sd5;                  // beq taken marker
            16: expected_value = rv_pkg::CAUSE_M_EXT;
            18: expected_value = rv_pkg::CAUSE_M_TIMER;
            default: expected_value = 64'd0;
        endcase
    endfunction

    function automatic logic [31:0] test_mask(input int t);
        case (t)
            0:       test_mask = 32'h0000_007f;
            1:       test_mask = 32'h0000_0080;
            2:       test_mask = 32'h0000_0f00;
            3:       test_mask = 32'h0003_0000;
            default: test_mask = 32'h000c_0000;
        endcase
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       test_name = "arithmetic";
            1:       test_name = "memory";
            2:       test_name = "control flow";
            3:       test_name = "external interrupt";
            default: test_name = "timer interrupt";
        endcase
    endfunction

    task automatic check_slot(input int slot, input logic [63:0] value);
        logic known;
        logic is_mepc;
        known   = slot <= 11 || (slot >= 16 && slot <= 19);
        is_mepc = slot == 17 || slot == 19;
        assert (slot != POISON_SLOT) else begin
            store_errors++;
            $display("store from a skipped instruction reached the mailbox at %0t", $time);
        end
        assert (known || slot == POISON_SLOT) else begin
            store_errors++;
            $display("unexpected store to mailbox slot %0d at %0t", slot, $time);
        end
        assert (!stored[slot]) else begin
            store_errors++;
            slot_bad[slot] = 1'b1;
            $display("mailbox slot %0d stored more than once at %0t", slot, $time);
        end
        // main program slots arrive in order, even across a trap
        if (slot <= 11) begin
            assert (slot > last_main) else begin
                store_errors++;
                slot_bad[slot] = 1'b1;
                $display("main program store to slot %0d out of order at %0t", slot, $time);
            end
            last_main = slot;
        end
        if (is_mepc) begin
            assert (value >= RESET_PC && value < RESET_PC + 64'hc0) else begin
                store_errors++;
                slot_bad[slot] = 1'b1;
                $display("mepc %h in slot %0d is outside the main program", value, slot);
            end
        end else if (known) begin
            assert (value == expected_value(slot)) else begin
                store_errors++;
                slot_bad[slot] = 1'b1;
                $display("Mismatch at %0t: mem_wdata slot %0d got %h expected %h",
                         $time, slot, value, expected_value(slot));
            end
        end
        stored[slot] = 1'b1;
    endtask

    always @(posedge clk) begin
        if (reset && mem_valid && mem_ready && mem_write) begin
            if (mem_addr == `RV_DONE_ADDR) begin
                // timer handler must have run before the end
                assert (stored[18]) else begin
                    store_errors++;
                    $display("done store arrived before the timer handler store");
                end
                done <= 1'b1;
            end else if (mem_addr >= MAILBOX && mem_addr < MAILBOX + 64'h100) begin
                check_slot(int'(mem_addr[7:3]), mem_wdata);
                if (mem_addr == MAILBOX) first_store <= 1'b1;
            end else if (mem_addr >= SCRATCH_BASE && mem_addr < SCRATCH_BASE + 64'h80) begin
                scratch[mem_addr[6:3]] <= mem_wdata;
            end
        end
    end

    // one line per test once all its slots are in
    always @(negedge clk) begin
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (!reported[t] && (stored & test_mask(t)) == test_mask(t)) begin
                reported[t] = 1'b1;
                if ((slot_bad & test_mask(t)) != 0) begin
                    tests_failed++;
                    $display("test %s: fail", test_name(t));
                end else begin
                    tests_passed++;
                    $display("test %s: pass", test_name(t));
                end
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!reset)
        mem_valid && !mem_ready |=> $stable(mem_addr) && $stable(mem_wdata))
        else begin
            stable_errors++;
            $display("memory request changed at %0t while waiting for ready", $time);
        end
endmodule

// File: dv/tb_rv_core.sv
`include "rv_params.svh"

module tb_rv_core;
    localparam int NUM_TESTS = 5;
    // about 60 instructions plus the timer wait, roughly 1000 cycles with
    // random ready, four times that as the limit
    localparam int TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        reset;
    logic [63:0] imem_addr;
    logic [31:0] imem_data;
    logic        mem_valid;
    logic        mem_write;
    logic [63:0] mem_addr;
    logic [63:0] mem_wdata;
    logic        mem_ready;
    logic [63:0] mem_rdata;
    logic        irq_ext = 1'b0;
    logic        irq_ack;
    logic        irq_raised = 1'b0;
    logic        first_store;
    logic        done;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count = 0;
    int          ack_count = 0;
    int          ack_errors = 0;

    rv_core_top uut (
        .clk, .reset, .imem_addr, .imem_data,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata, .mem_ready, .mem_rdata,
        .irq_ext, .irq_ack
    );

    tb_rv_mem u_mem (
        .clk, .reset, .imem_addr, .imem_data,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata, .mem_ready, .mem_rdata,
        .first_store, .done, .error_count, .tests_passed, .tests_failed
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

    // raise the line after the first mailbox store, drop it once the ack pulse is over
    always @(negedge clk) begin
        if (irq_ext && ack_count != 0) begin
            irq_ext = 1'b0;
        end else if (first_store && !irq_raised) begin
            irq_ext    = 1'b1;
            irq_raised = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (reset && irq_ack) ack_count++;
    end

    a_ack_with_irq: assert property (@(posedge clk) disable iff (!reset)
        irq_ack |-> irq_ext)
        else begin
            ack_errors++;
            $display("irq_ack pulsed at %0t with no external interrupt pending", $time);
        end

    task automatic end_run(input bit timed_out);
        int  errors;
        int  unfinished;
        errors     = error_count + ack_errors;
        unfinished = NUM_TESTS - tests_passed - tests_failed;
        if (!timed_out && ack_count != 1) begin
            errors++;
            $display("external interrupt acknowledged %0d times instead of once", ack_count);
        end
        $display("summary: %0d tests passed, %0d tests failed, %0d unfinished, %0d check errors",
                 tests_passed, tests_failed, unfinished, errors);
        if (!timed_out && tests_passed == NUM_TESTS && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (done) begin
            end_run(1'b0);
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: program did not reach the done store in %0d cycles",
                     TIMEOUT_CYCLES);
            end_run(1'b1);
        end
    end
endmodule

// File: compile.f
+incdir+design
design/rv_pkg.sv
design/rv_bus_if.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_csr.sv
design/rv_clint.sv
design/rv_exec_fsm.sv
design/rv_core_top.sv
dv/tb_rv_mem.sv
dv/tb_rv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -f compile.f --top-module tb_rv_core -o sim_rv_core

./obj_dir/sim_rv_core | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
else
    echo "simulation reported failure, see sim.log"
    exit 1
fi

// File: dv/program.hex
// one 32-bit instruction word per line, index 0 is the reset pc
// x10 mailbox base, x5 clint base, x20 handler slot pointer
00001517 // 00 auipc x10, 1
00000097 // 01 auipc x1, 0
0BC08093 // 02 addi  x1, x1, 0xbc
30509073 // 03 csrrw x0, mtvec, x1
020002B7 // 04 lui   x5, 0x2000
08050A13 // 05 addi  x20, x10, 128
12345137 // 06 lui   x2, 0x12345
00253023 // 07 sd    x2, 0(x10)
00A53423 // 08 sd    x10, 8(x10)
FFB00193 // 09 addi  x3, x0, -5
00353823 // 0a sd    x3, 16(x10)
00700213 // 0b addi  x4, x0, 7
00418333 // 0c add   x6, x3, x4
00653C23 // 0d sd    x6, 24(x10)
404183B3 // 0e sub   x7, x3, x4
02753023 // 0f sd    x7, 32(x10)
0041A433 // 10 slt   x8, x3, x4
02853423 // 11 sd    x8, 40(x10)
003224B3 // 12 slt   x9, x4, x3
02953823 // 13 sd    x9, 48(x10)
ABCDE5B7 // 14 lui   x11, 0xabcde
12358593 // 15 addi  x11, x11, 0x123
40050613 // 16 addi  x12, x10, 1024
00B63023 // 17 sd    x11, 0(x12)
00063683 // 18 ld    x13, 0(x12)
02D53C23 // 19 sd    x13, 56(x10)
0080076F // 1a jal   x14, +8
06053C23 // 1b sd    x0, 120(x10)
04E53023 // 1c sd    x14, 64(x10)
00000797 // 1d auipc x15, 0
00C78867 // 1e jalr  x16, 12(x15)
06053C23 // 1f sd    x0, 120(x10)
05053423 // 20 sd    x16, 72(x10)
00418463 // 21 beq   x3, x4, +8
04453823 // 22 sd    x4, 80(x10)
00420463 // 23 beq   x4, x4, +8
06053C23 // 24 sd    x0, 120(x10)
04353C23 // 25 sd    x3, 88(x10)
0002B883 // 26 ld    x17, 0(x5)
01488893 // 27 addi  x17, x17, 20
0112B423 // 28 sd    x17, 8(x5)
0A050C13 // 29 addi  x24, x10, 160
018A0463 // 2a beq   x20, x24, +8
FFDFF06F // 2b jal   x0, -4
7FC50C93 // 2c addi  x25, x10, 2044
7E0CBE23 // 2d sd    x0, 2044(x25)
0000006F // 2e jal   x0, 0
@30
34201AF3 // 30 csrrw x21, mcause, x0
015A3023 // 31 sd    x21, 0(x20)
34101B73 // 32 csrrw x22, mepc, x0
341B1073 // 33 csrrw x0, mepc, x22
016A3423 // 34 sd    x22, 8(x20)
010A0A13 // 35 addi  x20, x20, 16
FFF00B93 // 36 addi  x23, x0, -1
0172B423 // 37 sd    x23, 8(x5)
30200073 // 38 mret
